// ==== flist.f ====
bmu_pkg.sv
bmu_adder.sv
bmu_shifter.sv
bmu_bitcount.sv
bmu_bitlogic.sv
bit_manipulation_unit.sv
tb_bmu_assert.sv
tb_bmu.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the execute unit testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_bmu -f flist.f -o sim_bmu
# keep running past assertion errors so the summary is printed
./obj_dir/sim_bmu +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log
if grep -qx "Regression passed" sim.log; then
  exit 0
fi
exit 1

// ==== tb_bmu.sv ====
// testbench for the bit-manipulation execute unit
// directed vector table, xorshift random vectors
// per-vector checks, hold checks, timeout and summary

`timescale 1ns/100ps

module tb_bmu import bmu_pkg::*; ();

  // one table row, name kept in its own queue
  typedef struct packed {
    bmu_op_t         op;
    logic            ren;
    logic [xlen-1:0] rd;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] exp_res;
    logic            exp_err;
  } vec_t;

  logic            clk = 1'b0;
  logic            rst_n;
  logic            valid_in;
  bmu_op_t         op;
  logic            csr_ren;
  logic [xlen-1:0] csr_rddata;
  logic [xlen-1:0] a;
  logic [xlen-1:0] b;
  logic [xlen-1:0] result;
  logic            result_valid;
  logic            error;

  vec_t            vecs[$];
  string           names[$];
  int              fails = 0;
  int              cycles = 0;
  int              limit = 0;
  int              asrt_fails;
  logic [31:0]     rng;
  logic [31:0]     ra;
  logic [31:0]     rb;

  bit_manipulation_unit u_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .valid_in     (valid_in),
    .op           (op),
    .csr_ren      (csr_ren),
    .csr_rddata   (csr_rddata),
    .a            (a),
    .b            (b),
    .result       (result),
    .result_valid (result_valid),
    .error        (error)
  );

  bind bit_manipulation_unit tb_bmu_assert u_assert (
    .clk          (clk),
    .rst_n        (rst_n),
    .valid_in     (valid_in),
    .result       (result),
    .result_valid (result_valid),
    .error        (error)
  );

  // 40 ns period
  always #20 clk = ~clk;

  // run limit, set once the table is built
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit != 0 && cycles >= limit) begin
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("Regression failed");
      $finish;
    end
  end

  // xorshift32 step
  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] count_ones(input logic [31:0] x);
    logic [31:0] n;
    n = 32'h0;
    for (int i = 0; i < 32; i++) begin
      n = n + {31'h0, x[i]};
    end
    return n;
  endfunction

  // rotate left, shift by 32 gives 0 so n = 0 returns x
  function automatic logic [31:0] rotl(input logic [31:0] x, input int n);
    return (x << n) | (x >> (32 - n));
  endfunction

  task automatic push_vec(input string name, input bmu_op_t o,
                          input logic [31:0] va, input logic [31:0] vb,
                          input logic [31:0] res, input logic err = 1'b0,
                          input logic ren = 1'b0, input logic [31:0] rd = 32'h0);
    vec_t v;
    v.op      = o;
    v.ren     = ren;
    v.rd      = rd;
    v.a       = va;
    v.b       = vb;
    v.exp_res = res;
    v.exp_err = err;
    vecs.push_back(v);
    names.push_back(name);
  endtask

  // issue one op, check it, then check it holds through an idle cycle
  task automatic apply_and_check(input int idx);
    vec_t v;
    int   bad;
    v   = vecs[idx];
    bad = 0;
    @(posedge clk);
    valid_in   <= 1'b1;
    op         <= v.op;
    csr_ren    <= v.ren;
    csr_rddata <= v.rd;
    a          <= v.a;
    b          <= v.b;
    @(posedge clk);
    // idle with scrambled operands
    valid_in <= 1'b0;
    a        <= ~v.a;
    b        <= v.b ^ 32'h5a5a_5a5a;
    @(negedge clk);
    if (result_valid !== 1'b1) begin
      $display("[ERROR] %s result_valid expected 1 actual %b", names[idx], result_valid);
      bad++;
    end
    if (result !== v.exp_res) begin
      $display("[ERROR] %s result expected %h actual %h", names[idx], v.exp_res, result);
      bad++;
    end
    if (error !== v.exp_err) begin
      $display("[ERROR] %s error expected %b actual %b", names[idx], v.exp_err, error);
      bad++;
    end
    @(negedge clk);
    if (result_valid !== 1'b0) begin
      $display("[ERROR] %s idle result_valid expected 0 actual %b", names[idx], result_valid);
      bad++;
    end
    if (result !== v.exp_res) begin
      $display("[ERROR] %s held result expected %h actual %h", names[idx], v.exp_res, result);
      bad++;
    end
    if (bad == 0) begin
      $display("[ OK ] %s", names[idx]);
    end else begin
      $display("[FAIL] %s", names[idx]);
      fails++;
    end
  endtask

  initial begin
    rst_n      = 1'b0;
    valid_in   = 1'b0;
    op         = '0;
    csr_ren    = 1'b0;
    csr_rddata = '0;
    a          = '0;
    b          = '0;

    // arithmetic, slt/min/max issued with sub
    push_vec("add", bmu_op_t'{add: 1'b1, default: 1'b0}, 32'h12345678, 32'h11111111,
             32'h23456789);
    push_vec("sub", bmu_op_t'{sub: 1'b1, default: 1'b0}, 32'd5, 32'd7, 32'hfffffffe);
    push_vec("sh1add", bmu_op_t'{sh1add: 1'b1, zba: 1'b1, default: 1'b0}, 32'd3, 32'd10,
             32'd16);
    push_vec("sh2add", bmu_op_t'{sh2add: 1'b1, zba: 1'b1, default: 1'b0}, 32'd3, 32'd10,
             32'd22);
    push_vec("sh3add", bmu_op_t'{sh3add: 1'b1, zba: 1'b1, default: 1'b0}, 32'd3, 32'd10,
             32'd34);
    // negative a against positive b overflows the difference
    push_vec("slt_ovf", bmu_op_t'{sub: 1'b1, slt: 1'b1, default: 1'b0}, 32'h80000000,
             32'd1, 32'd1);
    push_vec("sltu_ovf", bmu_op_t'{sub: 1'b1, slt: 1'b1, unsign: 1'b1, default: 1'b0},
             32'h80000000, 32'd1, 32'd0);
    push_vec("slt_gt", bmu_op_t'{sub: 1'b1, slt: 1'b1, default: 1'b0}, 32'd5, 32'd3, 32'd0);
    push_vec("sltu_lt", bmu_op_t'{sub: 1'b1, slt: 1'b1, unsign: 1'b1, default: 1'b0},
             32'd3, 32'hffffffff, 32'd1);

    // logic and inverted forms
    push_vec("and", bmu_op_t'{land: 1'b1, default: 1'b0}, 32'hf0f01234, 32'hff00ff00,
             32'hf0001200);
    push_vec("or", bmu_op_t'{lor: 1'b1, default: 1'b0}, 32'hf0f01234, 32'hff00ff00,
             32'hfff0ff34);
    push_vec("xor", bmu_op_t'{lxor: 1'b1, default: 1'b0}, 32'hf0f01234, 32'hff00ff00,
             32'h0ff0ed34);
    push_vec("andn", bmu_op_t'{land: 1'b1, zbb: 1'b1, default: 1'b0}, 32'hf0f01234,
             32'hff00ff00, 32'h00f00034);
    push_vec("orn", bmu_op_t'{lor: 1'b1, zbb: 1'b1, default: 1'b0}, 32'hf0f01234,
             32'hff00ff00, 32'hf0ff12ff);
    push_vec("xnor", bmu_op_t'{lxor: 1'b1, zbb: 1'b1, default: 1'b0}, 32'hf0f01234,
             32'hff00ff00, 32'hf00f12cb);

    // single-bit ops at both ends of the word
    push_vec("bset_0", bmu_op_t'{bset: 1'b1, default: 1'b0}, 32'h00000f00, 32'd0, 32'h00000f01);
    push_vec("bset_31", bmu_op_t'{bset: 1'b1, default: 1'b0}, 32'h00000f00, 32'd31, 32'h80000f00);
    push_vec("bclr_0", bmu_op_t'{bclr: 1'b1, default: 1'b0}, 32'h80000001, 32'd0, 32'h80000000);
    push_vec("bclr_31", bmu_op_t'{bclr: 1'b1, default: 1'b0}, 32'h80000001, 32'd31, 32'h00000001);
    push_vec("binv_0", bmu_op_t'{binv: 1'b1, default: 1'b0}, 32'h00000f00, 32'd0, 32'h00000f01);
    push_vec("binv_31", bmu_op_t'{binv: 1'b1, default: 1'b0}, 32'h80000001, 32'd31, 32'h00000001);
    push_vec("bext_8", bmu_op_t'{bext: 1'b1, default: 1'b0}, 32'h00000100, 32'd8, 32'd1);
    push_vec("bext_9", bmu_op_t'{bext: 1'b1, default: 1'b0}, 32'h00000100, 32'd9, 32'd0);
    push_vec("bext_31", bmu_op_t'{bext: 1'b1, default: 1'b0}, 32'h80000000, 32'd31, 32'd1);
    push_vec("sext_b", bmu_op_t'{sext_b: 1'b1, default: 1'b0}, 32'h00000080, 32'd0, 32'hffffff80);
    push_vec("sext_h", bmu_op_t'{sext_h: 1'b1, default: 1'b0}, 32'h12348001, 32'd0, 32'hffff8001);

    // shifts and rotates of a word with both end bits set
    push_vec("sll_0", bmu_op_t'{sll: 1'b1, default: 1'b0}, 32'h80000001, 32'd0, 32'h80000001);
    push_vec("sll_1", bmu_op_t'{sll: 1'b1, default: 1'b0}, 32'h80000001, 32'd1, 32'h00000002);
    push_vec("sll_31", bmu_op_t'{sll: 1'b1, default: 1'b0}, 32'h80000001, 32'd31, 32'h80000000);
    push_vec("srl_0", bmu_op_t'{srl: 1'b1, default: 1'b0}, 32'h80000001, 32'd0, 32'h80000001);
    push_vec("srl_1", bmu_op_t'{srl: 1'b1, default: 1'b0}, 32'h80000001, 32'd1, 32'h40000000);
    push_vec("srl_31", bmu_op_t'{srl: 1'b1, default: 1'b0}, 32'h80000001, 32'd31, 32'h00000001);
    push_vec("sra_0", bmu_op_t'{sra: 1'b1, default: 1'b0}, 32'h80000001, 32'd0, 32'h80000001);
    push_vec("sra_1", bmu_op_t'{sra: 1'b1, default: 1'b0}, 32'h80000001, 32'd1, 32'hc0000000);
    push_vec("sra_31", bmu_op_t'{sra: 1'b1, default: 1'b0}, 32'h80000001, 32'd31, 32'hffffffff);
    push_vec("rol_0", bmu_op_t'{rol: 1'b1, default: 1'b0}, 32'h80000001, 32'd0, 32'h80000001);
    push_vec("rol_1", bmu_op_t'{rol: 1'b1, default: 1'b0}, 32'h80000001, 32'd1, 32'h00000003);
    push_vec("rol_31", bmu_op_t'{rol: 1'b1, default: 1'b0}, 32'h80000001, 32'd31, 32'hc0000000);
    push_vec("ror_0", bmu_op_t'{ror: 1'b1, default: 1'b0}, 32'h80000001, 32'd0, 32'h80000001);
    push_vec("ror_1", bmu_op_t'{ror: 1'b1, default: 1'b0}, 32'h80000001, 32'd1, 32'hc0000000);
    push_vec("ror_31", bmu_op_t'{ror: 1'b1, default: 1'b0}, 32'h80000001, 32'd31, 32'h00000003);

    // counts, zero word counts 32
    push_vec("clz_zero", bmu_op_t'{clz: 1'b1, default: 1'b0}, 32'h0, 32'd0, 32'd32);
    push_vec("clz_ones", bmu_op_t'{clz: 1'b1, default: 1'b0}, 32'hffffffff, 32'd0, 32'd0);
    push_vec("clz_bit", bmu_op_t'{clz: 1'b1, default: 1'b0}, 32'h00010000, 32'd0, 32'd15);
    push_vec("ctz_zero", bmu_op_t'{ctz: 1'b1, default: 1'b0}, 32'h0, 32'd0, 32'd32);
    push_vec("ctz_ones", bmu_op_t'{ctz: 1'b1, default: 1'b0}, 32'hffffffff, 32'd0, 32'd0);
    push_vec("ctz_bit", bmu_op_t'{ctz: 1'b1, default: 1'b0}, 32'h00010000, 32'd0, 32'd16);
    push_vec("cpop_zero", bmu_op_t'{cpop: 1'b1, default: 1'b0}, 32'h0, 32'd0, 32'd0);
    push_vec("cpop_ones", bmu_op_t'{cpop: 1'b1, default: 1'b0}, 32'hffffffff, 32'd0, 32'd32);
    push_vec("cpop_bit", bmu_op_t'{cpop: 1'b1, default: 1'b0}, 32'h00010000, 32'd0, 32'd1);

    // byte ops, packing, min/max with signed and unsigned orders apart
    push_vec("rev8", bmu_op_t'{grev: 1'b1, default: 1'b0}, 32'h11223344, 32'd24, 32'h44332211);
    push_vec("orc_b", bmu_op_t'{gorc: 1'b1, default: 1'b0}, 32'h00100001, 32'd7, 32'h00ff00ff);
    push_vec("pack", bmu_op_t'{pack: 1'b1, default: 1'b0}, 32'h12345678, 32'h9abcdef0,
             32'h5678def0);
    push_vec("packu", bmu_op_t'{packu: 1'b1, default: 1'b0}, 32'h12345678, 32'h9abcdef0,
             32'h12349abc);
    push_vec("packh", bmu_op_t'{packh: 1'b1, default: 1'b0}, 32'h12345678, 32'h9abcdef0,
             32'h000078f0);
    push_vec("min", bmu_op_t'{sub: 1'b1, min: 1'b1, default: 1'b0}, 32'hffffffff, 32'd1,
             32'hffffffff);
    push_vec("max", bmu_op_t'{sub: 1'b1, max: 1'b1, default: 1'b0}, 32'hffffffff, 32'd1,
             32'd1);
    push_vec("minu", bmu_op_t'{sub: 1'b1, min: 1'b1, unsign: 1'b1, default: 1'b0},
             32'hffffffff, 32'd1, 32'd1);
    push_vec("maxu", bmu_op_t'{sub: 1'b1, max: 1'b1, unsign: 1'b1, default: 1'b0},
             32'hffffffff, 32'd1, 32'hffffffff);

    // csr pass-through and the three error cases
    push_vec("csr_read", '0, 32'd5, 32'd6, 32'hcafef00d, 1'b0, 1'b1, 32'hcafef00d);
    push_vec("err_csr_op", bmu_op_t'{add: 1'b1, default: 1'b0}, 32'd5, 32'd6, 32'h0,
             1'b1, 1'b1, 32'hcafef00d);
    push_vec("err_sh_nozba", bmu_op_t'{sh1add: 1'b1, default: 1'b0}, 32'd3, 32'd10, 32'h0,
             1'b1);
    push_vec("err_zba_sub", bmu_op_t'{zba: 1'b1, sub: 1'b1, default: 1'b0}, 32'd3, 32'd10,
             32'h0, 1'b1);

    // random operands, expectations from the tb models
    rng = 32'he3df_0a55;
    for (int i = 0; i < 6; i++) begin
      rng = xorshift(rng);
      ra  = rng;
      rng = xorshift(rng);
      rb  = rng;
      push_vec("rnd_add", bmu_op_t'{add: 1'b1, default: 1'b0}, ra, rb, ra + rb);
      push_vec("rnd_xor", bmu_op_t'{lxor: 1'b1, default: 1'b0}, ra, rb, ra ^ rb);
      push_vec("rnd_cpop", bmu_op_t'{cpop: 1'b1, default: 1'b0}, ra, rb, count_ones(ra));
      push_vec("rnd_rol", bmu_op_t'{rol: 1'b1, default: 1'b0}, ra, rb,
               rotl(ra, int'(rb[4:0])));
    end

    limit = 4 * (vecs.size() + 1) + 20;

    // reset for 2 cycles, outputs must come up cleared
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    if (result !== '0 || error !== 1'b0 || result_valid !== 1'b0) begin
      $display("[ERROR] reset outputs expected 0/0/0 actual %h/%b/%b",
               result, error, result_valid);
      fails++;
    end else begin
      $display("[ OK ] reset");
    end

    for (int i = 0; i < vecs.size(); i++) begin
      apply_and_check(i);
    end

    asrt_fails = int'(u_dut.u_assert.assert_fails);
    $display("tests %0d, failed %0d, assertion failures %0d",
             vecs.size() + 1, fails, asrt_fails);
    if (fails == 0 && asrt_fails == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== tb_bmu_assert.sv ====
// concurrent checks on the execute unit ports
// reset, valid timing, error zeroing, idle hold

`timescale 1ns/100ps

module tb_bmu_assert import bmu_pkg::*; (
  input logic            clk,
  input logic            rst_n,
  input logic            valid_in,
  input logic [xlen-1:0] result,
  input logic            result_valid,
  input logic            error
);

  // read back by the testbench at the end
  int unsigned assert_fails = 0;

  // no valid output while in reset
  a_rst_clear: assert property (@(posedge clk) !rst_n |-> !result_valid)
    else begin
      $error("result_valid high while rst_n is low");
      assert_fails++;
    end

  // exactly one cycle of latency
  a_valid_rise: assert property (@(posedge clk) disable iff (!rst_n)
    valid_in |=> result_valid)
    else begin
      $error("result_valid missing one cycle after valid_in");
      assert_fails++;
    end

  a_valid_fall: assert property (@(posedge clk) disable iff (!rst_n)
    !valid_in |=> !result_valid)
    else begin
      $error("result_valid high without valid_in");
      assert_fails++;
    end

  // error forces a zero result
  a_err_zero: assert property (@(posedge clk) error |-> result == '0)
    else begin
      $error("result nonzero while error is set");
      assert_fails++;
    end

  // idle cycles leave result alone
  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    !result_valid |-> $stable(result))
    else begin
      $error("result changed while result_valid is low");
      assert_fails++;
    end

endmodule

// ==== bit_manipulation_unit.sv ====
// bit-manipulation execute unit top level
// extension gating, error check, result merge
// registered result, error and result_valid

`timescale 1ns/100ps

module bit_manipulation_unit import bmu_pkg::*; #(
  parameter bit zbb_en = 1'b1,
  parameter bit zbs_en = 1'b1,
  parameter bit zba_en = 1'b1,
  parameter bit zbp_en = 1'b1
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              valid_in,
  input  bmu_op_t           op,
  input  logic              csr_ren,
  input  logic [xlen-1:0]   csr_rddata,
  input  logic [xlen-1:0]   a,
  input  logic [xlen-1:0]   b,
  output logic [xlen-1:0]   result,
  output logic              result_valid,
  output logic              error
);

  // rotates and byte ops exist in zbb or zbp
  localparam bit zbx_en = zbb_en | zbp_en;

  bmu_ctl_t         ctl;
  logic [xlen-1:0]  sum;
  logic [xlen-1:0]  sout;
  logic [xlen-1:0]  lout;
  logic [cnt_w-1:0] count;
  logic             lt;
  logic             err_d;
  logic [xlen-1:0]  merged;
  logic [xlen-1:0]  result_d;

  always_comb begin
    // base integer ops always on
    ctl.add    = op.add;
    ctl.sub    = op.sub;
    ctl.unsign = op.unsign;
    ctl.slt    = op.slt;
    ctl.land   = op.land;
    ctl.lor    = op.lor;
    ctl.lxor   = op.lxor;
    ctl.sll    = op.sll;
    ctl.srl    = op.srl;
    ctl.sra    = op.sra;
    // zbb only
    ctl.clz    = op.clz & zbb_en;
    ctl.ctz    = op.ctz & zbb_en;
    ctl.cpop   = op.cpop & zbb_en;
    ctl.sext_b = op.sext_b & zbb_en;
    ctl.sext_h = op.sext_h & zbb_en;
    ctl.min    = op.min & zbb_en;
    ctl.max    = op.max & zbb_en;
    // zbb or zbp
    ctl.zbb    = op.zbb & zbx_en;
    ctl.rol    = op.rol & zbx_en;
    ctl.ror    = op.ror & zbx_en;
    ctl.pack   = op.pack & zbx_en;
    ctl.packh  = op.packh & zbx_en;
    // grev/gorc only as rev8 (b=24) and orc.b (b=7)
    ctl.rev8   = op.grev & zbx_en & (b[shamt_w-1:0] == 5'd24);
    ctl.orc_b  = op.gorc & zbx_en & (b[shamt_w-1:0] == 5'd7);
    // zbp only
    ctl.packu  = op.packu & zbp_en;
    // zbs
    ctl.bset   = op.bset & zbs_en;
    ctl.bclr   = op.bclr & zbs_en;
    ctl.binv   = op.binv & zbs_en;
    ctl.bext   = op.bext & zbs_en;
    // zba
    ctl.sh1add = op.sh1add & zba_en;
    ctl.sh2add = op.sh2add & zba_en;
    ctl.sh3add = op.sh3add & zba_en;
    ctl.zba    = op.zba & zba_en;
  end

  bmu_adder u_adder (
    .ctl (ctl),
    .a   (a),
    .b   (b),
    .sum (sum),
    .lt  (lt)
  );

  bmu_shifter u_shifter (
    .ctl  (ctl),
    .a    (a),
    .b    (b),
    .sout (sout)
  );

  bmu_bitcount u_bitcount (
    .ctl   (ctl),
    .a     (a),
    .count (count)
  );

  bmu_bitlogic u_bitlogic (
    .ctl  (ctl),
    .a    (a),
    .b    (b),
    .lt   (lt),
    .lout (lout)
  );

  // csr read must come alone
  // shNadd needs zba, zba never subtracts
  assign err_d = (csr_ren & (op != '0)) |
                 (~ctl.zba & (ctl.sh1add | ctl.sh2add | ctl.sh3add)) |
                 (ctl.zba & ctl.sub);

  // unselected paths are already zero
  assign merged = sum | sout | lout |
                  {{(xlen-cnt_w){1'b0}}, count} |
                  {{(xlen-1){1'b0}}, ctl.slt & lt} |
                  (csr_ren ? csr_rddata : '0);

  assign result_d = err_d ? '0 : merged;

  // one-cycle latency, hold when idle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result       <= '0;
      error        <= 1'b0;
      result_valid <= 1'b0;
    end else begin
      result_valid <= valid_in;
      if (valid_in) begin
        result <= result_d;
        error  <= err_d;
      end
    end
  end

endmodule

// ==== bmu_bitlogic.sv ====
// logic and bit-field path
// and/or/xor and inverted forms, sign extension, packing
// rev8, orc.b, single-bit ops and min/max selection

`timescale 1ns/100ps

module bmu_bitlogic import bmu_pkg::*; (
  input  bmu_ctl_t          ctl,
  input  logic [xlen-1:0]   a,
  input  logic [xlen-1:0]   b,
  input  logic              lt,
  output logic [xlen-1:0]   lout
);

  logic [xlen-1:0] logic_res;
  logic [xlen-1:0] sext_res;
  logic [xlen-1:0] pack_res;
  logic [xlen-1:0] byte_res;
  logic [xlen-1:0] onehot;
  logic [xlen-1:0] sb_res;
  logic [xlen-1:0] minmax_res;
  logic            sel_a;

  // zbb turns and/or/xor into andn/orn/xnor
  assign logic_res = ({xlen{ctl.land & ~ctl.zbb}} & (a &  b)) |
                     ({xlen{ctl.lor  & ~ctl.zbb}} & (a |  b)) |
                     ({xlen{ctl.lxor & ~ctl.zbb}} & (a ^  b)) |
                     ({xlen{ctl.land &  ctl.zbb}} & (a & ~b)) |
                     ({xlen{ctl.lor  &  ctl.zbb}} & (a | ~b)) |
                     ({xlen{ctl.lxor &  ctl.zbb}} & (a ^ ~b));

  assign sext_res = ({xlen{ctl.sext_b}} & {{24{a[7]}}, a[7:0]}) |
                    ({xlen{ctl.sext_h}} & {{16{a[15]}}, a[15:0]});

  // halves or low bytes of a and b side by side
  assign pack_res = ({xlen{ctl.pack}}  & {a[15:0], b[15:0]}) |
                    ({xlen{ctl.packu}} & {a[31:16], b[31:16]}) |
                    ({xlen{ctl.packh}} & {16'b0, a[7:0], b[7:0]});

  // rev8 swaps byte order
  // orc.b fills any nonzero byte with ones
  assign byte_res = ({xlen{ctl.rev8}}  & {a[7:0], a[15:8], a[23:16], a[31:24]}) |
                    ({xlen{ctl.orc_b}} & {{8{|a[31:24]}}, {8{|a[23:16]}},
                                          {8{|a[15:8]}}, {8{|a[7:0]}}});

  // bit index from b[4:0]
  assign onehot = {{(xlen-1){1'b0}}, 1'b1} << b[shamt_w-1:0];

  assign sb_res = ({xlen{ctl.bset}} & (a |  onehot)) |
                  ({xlen{ctl.bclr}} & (a & ~onehot)) |
                  ({xlen{ctl.binv}} & (a ^  onehot));

  // min keeps a when a < b, max keeps a when a >= b
  assign sel_a = ctl.min ? lt : ~lt;
  assign minmax_res = (ctl.min | ctl.max) ? (sel_a ? a : b) : '0;

  assign lout = logic_res | sext_res | pack_res | byte_res | sb_res | minmax_res;

endmodule

// ==== bmu_bitcount.sv ====
// bit counting path
// clz / ctz leading-zero encoder and cpop population count

`timescale 1ns/100ps

module bmu_bitcount import bmu_pkg::*; (
  input  bmu_ctl_t          ctl,
  input  logic [xlen-1:0]   a,
  output logic [cnt_w-1:0]  count
);

  logic [xlen-1:0]  a_rev;
  logic [xlen-1:0]  lzd_in;
  logic [cnt_w-1:0] lz;
  logic [cnt_w-1:0] pop;

  // ctz is clz of the bit-reversed word
  always_comb begin
    for (int i = 0; i < xlen; i++) begin
      a_rev[i] = a[xlen-1-i];
    end
  end

  assign lzd_in = ctl.ctz ? a_rev : a;

  // highest set bit wins, all-zero word counts 32
  always_comb begin
    lz = cnt_w'(xlen);
    for (int i = 0; i < xlen; i++) begin
      if (lzd_in[i]) begin
        lz = cnt_w'(xlen - 1 - i);
      end
    end
  end

  // population count over the full word
  always_comb begin
    pop = '0;
    for (int i = 0; i < xlen; i++) begin
      pop = pop + {{(cnt_w-1){1'b0}}, a[i]};
    end
  end

  always_comb begin
    if (ctl.clz | ctl.ctz) begin
      count = lz;
    end else if (ctl.cpop) begin
      count = pop;
    end else begin
      count = '0;
    end
  end

endmodule

// ==== bmu_shifter.sv ====
// shift and rotate path
// sll, srl, sra, rol, ror and bext through one funnel shift

`timescale 1ns/100ps

module bmu_shifter import bmu_pkg::*; (
  input  bmu_ctl_t          ctl,
  input  logic [xlen-1:0]   a,
  input  logic [xlen-1:0]   b,
  output logic [xlen-1:0]   sout
);

  logic [shamt_w-1:0]  rshamt;
  logic [shamt_w-1:0]  lshamt;
  logic [shamt_w-1:0]  amt;
  logic [2*xlen-2:0]   ext;
  logic [2*xlen-2:0]   shifted;
  logic [xlen-1:0]     mask;
  logic                sel_shift;
  logic                left;

  assign rshamt = b[shamt_w-1:0];
  // 32-complement, wraps 0 back to 0
  assign lshamt = ~rshamt + 1'b1;

  // left shifts run as a right rotate by 32 - n
  assign left = ctl.sll | ctl.rol;
  assign amt  = left ? lshamt : rshamt;

  // upper fill: sign for sra, a itself for rotates and sll
  always_comb begin
    ext[xlen-1:0] = a;
    if (ctl.sra) begin
      ext[2*xlen-2:xlen] = {(xlen-1){a[xlen-1]}};
    end else if (ctl.rol | ctl.ror | ctl.sll) begin
      ext[2*xlen-2:xlen] = a[xlen-2:0];
    end else begin
      ext[2*xlen-2:xlen] = '0;
    end
  end

  assign shifted = ext >> amt;

  // sll clears the bits rotated in from the top
  assign mask = {xlen{1'b1}} << (ctl.sll ? rshamt : {shamt_w{1'b0}});

  assign sel_shift = ctl.sll | ctl.srl | ctl.sra | ctl.rol | ctl.ror;

  always_comb begin
    if (sel_shift) begin
      sout = shifted[xlen-1:0] & mask;
    end else if (ctl.bext) begin
      // single extracted bit, zero-extended
      sout = {{(xlen-1){1'b0}}, shifted[0]};
    end else begin
      sout = '0;
    end
  end

endmodule

// ==== bmu_adder.sv ====
// adder path of the execute unit
// zba pre-shift, add/sub, signed and unsigned less-than

`timescale 1ns/100ps

module bmu_adder import bmu_pkg::*; (
  input  bmu_ctl_t          ctl,
  input  logic [xlen-1:0]   a,
  input  logic [xlen-1:0]   b,
  output logic [xlen-1:0]   sum,
  output logic              lt
);

  logic [xlen-1:0] a_sh;
  logic [xlen-1:0] bm;
  logic [xlen-1:0] raw;
  logic            cout;
  logic            ov;
  logic            sel_adder;

  // shNadd pre-shift of operand a
  always_comb begin
    if (ctl.sh3add) begin
      a_sh = {a[xlen-4:0], 3'b000};
    end else if (ctl.sh2add) begin
      a_sh = {a[xlen-3:0], 2'b00};
    end else if (ctl.sh1add) begin
      a_sh = {a[xlen-2:0], 1'b0};
    end else begin
      a_sh = a;
    end
  end

  // subtract as a + ~b + 1
  assign bm = ctl.sub ? ~b : b;
  assign {cout, raw} = {1'b0, a_sh} + {1'b0, bm} + {{xlen{1'b0}}, ctl.sub};

  // signed overflow from operand and sum signs
  assign ov = (~a_sh[xlen-1] & ~bm[xlen-1] &  raw[xlen-1]) |
              ( a_sh[xlen-1] &  bm[xlen-1] & ~raw[xlen-1]);

  // unsigned borrow means a < b
  assign lt = ctl.unsign ? ~cout : (raw[xlen-1] ^ ov);

  // compare-only ops keep the sum off the result bus
  assign sel_adder = (ctl.add | ctl.sub | ctl.zba) & ~ctl.slt & ~ctl.min & ~ctl.max;
  assign sum = sel_adder ? raw : '0;

endmodule

// ==== bmu_pkg.sv ====
// bit-manipulation execute unit shared definitions
// data, shift-amount and count widths
// predecoded operation flags and gated control struct

package bmu_pkg;

  localparam int xlen    = 32;
  localparam int shamt_w = 5;
  // count result must hold 0 to 32
  localparam int cnt_w   = 6;

  // predecoded operation flags, one bit each
  typedef struct packed {
    // arithmetic
    logic add;
    logic sub;
    logic unsign;
    logic slt;
    // logic, zbb selects the inverted-b forms
    logic land;
    logic lor;
    logic lxor;
    logic zbb;
    // shifts and rotates
    logic sll;
    logic srl;
    logic sra;
    logic rol;
    logic ror;
    logic bext;
    // counts and sign extension
    logic clz;
    logic ctz;
    logic cpop;
    logic sext_b;
    logic sext_h;
    // selection and packing
    logic min;
    logic max;
    logic pack;
    logic packu;
    logic packh;
    // generalized reverse / or-combine
    logic grev;
    logic gorc;
    // single-bit ops
    logic bset;
    logic bclr;
    logic binv;
    // shift-and-add
    logic sh1add;
    logic sh2add;
    logic sh3add;
    logic zba;
  } bmu_op_t;

  // same flags after extension gating
  // rev8 / orc_b already qualified by operand b
  typedef struct packed {
    logic add;
    logic sub;
    logic unsign;
    logic slt;
    logic land;
    logic lor;
    logic lxor;
    logic zbb;
    logic sll;
    logic srl;
    logic sra;
    logic rol;
    logic ror;
    logic bext;
    logic clz;
    logic ctz;
    logic cpop;
    logic sext_b;
    logic sext_h;
    logic min;
    logic max;
    logic pack;
    logic packu;
    logic packh;
    logic rev8;
    logic orc_b;
    logic bset;
    logic bclr;
    logic binv;
    logic sh1add;
    logic sh2add;
    logic sh3add;
    logic zba;
  } bmu_ctl_t;

endpackage
